//--- haar_integral_window.f
verilog/haar_pkg.sv
verilog/wb_pixel_port.sv
verilog/row_line_buffer.sv
verilog/window_integrator.sv
verilog/window_readout.sv
verilog/haar_integral_window.sv
dv/haar_checker.sv
dv/haar_properties.sv
dv/haar_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module haar_tb \
	-f haar_integral_window.f --Mdir obj_dir -o haar_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/haar_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -F '*** FAILED ***' sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without failure"
exit 0

//--- dv/haar_tb.sv
`timescale 1ns/1ps

module haar_tb;

	localparam int CLK_PERIOD = 10;
	localparam int ACK_LIMIT = 4;
	// transfers of the five tests in order
	localparam int PLANNED_XFERS = 10 + 25 + (120 + 15 * 10) + 80 + (25 + 10 + 60);
	localparam int TIMEOUT_NS = PLANNED_XFERS * 6 * CLK_PERIOD;

	logic                           clk_os;
	logic                           reset_os;
	logic                           wb_cyc;
	logic                           wb_stb;
	logic                           wb_we;
	logic [haar_pkg::WB_ADDR_W-1:0] wb_adr;
	logic [haar_pkg::WB_DATA_W-1:0] wb_wdat;
	logic                           wb_ack;
	logic [haar_pkg::WB_DATA_W-1:0] wb_rdat;
	logic                           ready;
	logic [31:0]                    rng;
	int                             checks;
	int                             mismatches;
	int                             bus_errors;
	int                             checks_mark;
	int                             errors_mark;

	haar_integral_window dut (
		.i_clk_os   (clk_os),
		.i_reset_os (reset_os),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_adr   (wb_adr),
		.i_wb_dat   (wb_wdat),
		.o_wb_ack   (wb_ack),
		.o_wb_dat   (wb_rdat),
		.o_ready    (ready)
	);

	haar_checker chk (
		.i_clk_os   (clk_os),
		.i_reset_os (reset_os),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_adr   (wb_adr),
		.i_wb_dat   (wb_wdat),
		.i_wb_ack   (wb_ack),
		.i_rd_dat   (wb_rdat),
		.i_ready    (ready),
		.o_checks   (checks),
		.o_errors   (mismatches)
	);

	initial
	begin
		clk_os = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk_os = ~clk_os;
	end

	function automatic logic [31:0] next_random();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic int total_errors();
		return mismatches + bus_errors + dut.props.assert_fails;
	endfunction

	// starts and ends on a falling edge
	task automatic wb_access(input logic we, input logic [haar_pkg::WB_ADDR_W-1:0] adr,
		input logic [haar_pkg::WB_DATA_W-1:0] dat);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_wdat = dat;
		@(negedge clk_os);
		while (wb_ack !== 1'b1 && waited < ACK_LIMIT)
		begin
			waited++;
			@(negedge clk_os);
		end
		if (wb_ack !== 1'b1)
		begin
			$display("bus error: no ack within %0d cycles at address 0x%h", ACK_LIMIT, adr);
			bus_errors++;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		repeat (next_random() % 4)
			@(negedge clk_os);
	endtask

	task automatic wb_write(input logic [haar_pkg::WB_ADDR_W-1:0] adr,
		input logic [haar_pkg::WB_DATA_W-1:0] dat);
		wb_access(1'b1, adr, dat);
	endtask

	task automatic wb_read(input logic [haar_pkg::WB_ADDR_W-1:0] adr);
		wb_access(1'b0, adr, '0);
	endtask

	// upper data bits are random too and must be dropped
	task automatic push_pixel();
		wb_write(haar_pkg::ADDR_PIXEL, 16'(next_random()));
	endtask

	task automatic read_random_entry();
		wb_read(haar_pkg::ADDR_WIN_BASE + 4'(next_random() % 9));
	endtask

	task automatic read_all();
		wb_read(haar_pkg::ADDR_STATUS);
		for (int e = 0; e < haar_pkg::WIN_N; e++)
		begin
			wb_read(haar_pkg::ADDR_WIN_BASE + 4'(e));
		end
	endtask

	task automatic apply_reset();
		reset_os = 1'b1;
		repeat (2)
			@(negedge clk_os);
		reset_os = 1'b0;
	endtask

	task automatic report_test(input string name);
		repeat (2)
			@(negedge clk_os);
		$display("%s: %0d reads checked, %0d errors", name, checks - checks_mark,
			total_errors() - errors_mark);
		checks_mark = checks;
		errors_mark = total_errors();
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog: tests still running after %0d ns", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		rng = 32'd62;
		reset_os = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		bus_errors = 0;
		checks_mark = 0;
		errors_mark = 0;
		apply_reset();

		read_all();
		report_test("after reset");

		repeat (haar_pkg::READY_COUNT - 1)
			push_pixel();
		wb_read(haar_pkg::ADDR_STATUS);
		push_pixel();
		wb_read(haar_pkg::ADDR_STATUS);
		report_test("ready timing");

		for (int i = 1; i <= 60; i++)
		begin
			push_pixel();
			read_random_entry();
			if (i % 4 == 0)
				read_all();
		end
		report_test("integral values");

		// writes off address 0 leave the window alone
		repeat (80)
		begin
			if (next_random() % 2 == 1)
				wb_write(4'(next_random()), 16'(next_random()));
			else
				wb_read(4'(next_random()));
		end
		report_test("bus decode");

		repeat (25)
			push_pixel();
		apply_reset();
		read_all();
		repeat (30)
		begin
			push_pixel();
			read_random_entry();
		end
		report_test("reset mid-stream");

		$display("all tests: %0d reads checked, %0d errors", checks, total_errors());
		if (total_errors() == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- dv/haar_properties.sv
`timescale 1ns/1ps

module haar_properties (
	input logic i_clk_os,
	input logic i_reset_os,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack,
	input logic i_ready
);

	// count of failed assertions
	int assert_fails = 0;

	// ack answers a request seen one edge earlier
	ack_after_request: assert property (@(posedge i_clk_os) disable iff (i_reset_os)
		i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
	else
	begin
		assert_fails++;
		$error("ack raised without a cyc and stb request");
	end

	ack_single_cycle: assert property (@(posedge i_clk_os) disable iff (i_reset_os)
		i_wb_ack |=> !i_wb_ack)
	else
	begin
		assert_fails++;
		$error("ack held high for two cycles");
	end

	request_acked: assert property (@(posedge i_clk_os) disable iff (i_reset_os)
		(i_wb_cyc && i_wb_stb && !i_wb_ack) |=> i_wb_ack)
	else
	begin
		assert_fails++;
		$error("pending request not acked on the next cycle");
	end

	// only reset clears the ready flag
	ready_sticky: assert property (@(posedge i_clk_os)
		(i_ready && !i_reset_os) |=> i_ready)
	else
	begin
		assert_fails++;
		$error("ready fell without reset");
	end

endmodule

bind haar_integral_window haar_properties props (
	.i_clk_os   (i_clk_os),
	.i_reset_os (i_reset_os),
	.i_wb_cyc   (i_wb_cyc),
	.i_wb_stb   (i_wb_stb),
	.i_wb_ack   (o_wb_ack),
	.i_ready    (o_ready)
);

//--- dv/haar_checker.sv
`timescale 1ns/1ps

module haar_checker (
	input  logic                             i_clk_os,
	input  logic                             i_reset_os,
	input  logic                             i_wb_cyc,
	input  logic                             i_wb_stb,
	input  logic                             i_wb_we,
	input  logic [haar_pkg::WB_ADDR_W-1:0]   i_wb_adr,
	input  logic [haar_pkg::WB_DATA_W-1:0]   i_wb_dat,
	input  logic                             i_wb_ack,
	input  logic [haar_pkg::WB_DATA_W-1:0]   i_rd_dat,
	input  logic                             i_ready,
	output int                               o_checks,
	output int                               o_errors
);

	// newest pixel at the back of the queue
	logic [haar_pkg::PIXEL_W-1:0]   history [$];
	int                             push_count = 0;
	int                             checks = 0;
	int                             errors = 0;
	logic                           req_we;
	logic [haar_pkg::WB_ADDR_W-1:0] req_adr;
	logic [haar_pkg::WB_DATA_W-1:0] req_dat;
	logic [haar_pkg::WB_DATA_W-1:0] exp_dat;
	logic                           exp_ready;

	assign o_checks = checks;
	assign o_errors = errors;

	// pixel pushed age pushes ago or zero before the stream began
	function automatic int pixel_ago(input int age);
		int idx;
		idx = history.size() - 1 - age;
		return (idx < 0) ? 0 : int'(history[idx]);
	endfunction

	function automatic int expected_read(input logic [haar_pkg::WB_ADDR_W-1:0] adr);
		int entry;
		int sum;
		entry = int'(adr) - int'(haar_pkg::ADDR_WIN_BASE);
		sum = 0;
		if (adr == haar_pkg::ADDR_STATUS)
			return (push_count >= haar_pkg::READY_COUNT) ? 1 : 0;
		if (entry < 0 || entry >= haar_pkg::WIN_W * haar_pkg::WIN_H)
			return 0;
		// entry (y, x) adds every pixel at row <= y and column <= x
		for (int y = 0; y <= entry / haar_pkg::WIN_W; y++)
		begin
			for (int x = 0; x <= entry % haar_pkg::WIN_W; x++)
			begin
				sum += pixel_ago((haar_pkg::WIN_H - 1 - y) * haar_pkg::FRAME_W
					+ haar_pkg::WIN_W - 1 - x);
			end
		end
		return sum;
	endfunction

	// request captured when first seen and judged at the edge closing the ack
	always @(posedge i_clk_os)
	begin
		// ready seen here reflects every push counted before this edge
		exp_ready = (push_count >= haar_pkg::READY_COUNT);
		if (!i_reset_os && i_ready !== exp_ready)
		begin
			errors++;
			$display("MISMATCH o_ready: expected 0x%h, got 0x%h", exp_ready, i_ready);
		end
		if (i_reset_os)
		begin
			history.delete();
			push_count = 0;
		end
		else if (i_wb_ack)
		begin
			if (req_we && req_adr == haar_pkg::ADDR_PIXEL)
			begin
				history.push_back(req_dat[haar_pkg::PIXEL_W-1:0]);
				push_count++;
				if (history.size() > haar_pkg::READY_COUNT)
					void'(history.pop_front());
			end
			else if (!req_we)
			begin
				exp_dat = 16'(expected_read(req_adr));
				checks++;
				if (i_rd_dat !== exp_dat)
				begin
					errors++;
					$display("MISMATCH o_wb_dat address 0x%h: expected 0x%h, got 0x%h",
						req_adr, exp_dat, i_rd_dat);
				end
			end
		end
		else if (i_wb_cyc && i_wb_stb)
		begin
			req_we = i_wb_we;
			req_adr = i_wb_adr;
			req_dat = i_wb_dat;
		end
	end

endmodule

//--- verilog/haar_integral_window.sv
`timescale 1ns/1ps

module haar_integral_window (
	input  logic                             i_clk_os,
	input  logic                             i_reset_os,
	input  logic                             i_wb_cyc,
	input  logic                             i_wb_stb,
	input  logic                             i_wb_we,
	input  logic [haar_pkg::WB_ADDR_W-1:0]   i_wb_adr,
	input  logic [haar_pkg::WB_DATA_W-1:0]   i_wb_dat,
	output logic                             o_wb_ack,
	output logic [haar_pkg::WB_DATA_W-1:0]   o_wb_dat,
	output logic                             o_ready
);

	logic                           push;
	logic [haar_pkg::PIXEL_W-1:0]   pixel;
	logic [haar_pkg::WB_ADDR_W-1:0] rd_adr;

	// chain[k] feeds row k; the oldest row's shift output leaves the window
	wire [haar_pkg::WIN_H:0][haar_pkg::PIXEL_W-1:0]                        chain;
	wire [haar_pkg::WIN_H-1:0][haar_pkg::WIN_W-1:0][haar_pkg::PIXEL_W-1:0] taps;
	wire [haar_pkg::WIN_N-1:0][haar_pkg::SUM_W-1:0]                        sums;

	wb_pixel_port u_port (
		.i_clk_os   (i_clk_os),
		.i_reset_os (i_reset_os),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_adr   (i_wb_adr),
		.i_wb_dat   (i_wb_dat),
		.o_wb_ack   (o_wb_ack),
		.o_push     (push),
		.o_pixel    (pixel),
		.o_rd_adr   (rd_adr)
	);

	assign chain[0] = pixel;

	// all rows shift together on each push
	for (genvar k = 0; k < haar_pkg::WIN_H; k++)
	begin : g_line
		row_line_buffer u_row (
			.i_clk_os    (i_clk_os),
			.i_reset_os  (i_reset_os),
			.i_push      (push),
			.i_pixel     (chain[k]),
			.o_taps      (taps[k]),
			.o_pixel_out (chain[k+1])
		);
	end

	window_integrator u_integrator (
		.i_clk_os   (i_clk_os),
		.i_reset_os (i_reset_os),
		.i_push     (push),
		.i_taps     (taps),
		.o_sums     (sums)
	);

	window_readout u_readout (
		.i_clk_os   (i_clk_os),
		.i_reset_os (i_reset_os),
		.i_push     (push),
		.i_rd_adr   (rd_adr),
		.i_sums     (sums),
		.o_wb_dat   (o_wb_dat),
		.o_ready    (o_ready)
	);

endmodule

//--- verilog/window_readout.sv
`timescale 1ns/1ps

module window_readout (
	input  logic                                             i_clk_os,
	input  logic                                             i_reset_os,
	input  logic                                             i_push,
	input  logic [haar_pkg::WB_ADDR_W-1:0]                   i_rd_adr,
	input  logic [haar_pkg::WIN_N-1:0][haar_pkg::SUM_W-1:0]  i_sums,
	output logic [haar_pkg::WB_DATA_W-1:0]                   o_wb_dat,
	output logic                                             o_ready
);

	logic [haar_pkg::READY_CNT_W-1:0] push_cnt;
	logic                             ready_q;

	// counter stops once ready is set
	always_ff @(posedge i_clk_os)
	begin
		if (i_reset_os)
		begin
			push_cnt <= '0;
			ready_q <= 1'b0;
		end
		else if (i_push && !ready_q)
		begin
			push_cnt <= push_cnt + 1'b1;
			if (push_cnt == haar_pkg::READY_COUNT - 1)
				ready_q <= 1'b1;
		end
	end

	assign o_ready = ready_q;

	// read data sampled by the master during ack
	always_comb
	begin
		o_wb_dat = '0;
		if (i_rd_adr == haar_pkg::ADDR_STATUS)
			o_wb_dat[0] = ready_q;
		for (int i = 0; i < haar_pkg::WIN_N; i++)
		begin
			// window entries are zero extended to the bus width
			if (i_rd_adr == haar_pkg::ADDR_WIN_BASE + i)
				o_wb_dat[haar_pkg::SUM_W-1:0] = i_sums[i];
		end
	end

endmodule

//--- verilog/window_integrator.sv
`timescale 1ns/1ps

module window_integrator (
	input  logic i_clk_os,
	input  logic i_reset_os,
	input  logic i_push,
	input  logic [haar_pkg::WIN_H-1:0][haar_pkg::WIN_W-1:0][haar_pkg::PIXEL_W-1:0] i_taps,
	output logic [haar_pkg::WIN_N-1:0][haar_pkg::SUM_W-1:0] o_sums
);

	logic                         push_q;
	logic [haar_pkg::SUM_W-1:0]   pix      [haar_pkg::WIN_H][haar_pkg::WIN_W];
	logic [haar_pkg::SUM_W-1:0]   row_acc  [haar_pkg::WIN_H][haar_pkg::WIN_W];
	logic [haar_pkg::SUM_W-1:0]   area_acc [haar_pkg::WIN_H][haar_pkg::WIN_W];

	for (genvar y = 0; y < haar_pkg::WIN_H; y++)
	begin : g_row
		for (genvar x = 0; x < haar_pkg::WIN_W; x++)
		begin : g_col
			// y = 0 is the last row of the chain, x = 0 the oldest tap
			assign pix[y][x] = {{(haar_pkg::SUM_W - haar_pkg::PIXEL_W){1'b0}},
				i_taps[haar_pkg::WIN_H-1-y][haar_pkg::WIN_W-1-x]};

			// running sum along the row
			if (x == 0)
			begin : g_row_first
				assign row_acc[y][x] = pix[y][x];
			end
			else
			begin : g_row_next
				assign row_acc[y][x] = row_acc[y][x-1] + pix[y][x];
			end

			// row sums reduced down the window
			if (y == 0)
			begin : g_area_first
				assign area_acc[y][x] = row_acc[y][x];
			end
			else
			begin : g_area_next
				assign area_acc[y][x] = area_acc[y-1][x] + row_acc[y][x];
			end
		end
	end

	// taps settle on the push edge, sums follow one edge later
	always_ff @(posedge i_clk_os)
	begin
		if (i_reset_os)
		begin
			push_q <= 1'b0;
			o_sums <= '0;
		end
		else
		begin
			push_q <= i_push;
			if (push_q)
			begin
				for (int y = 0; y < haar_pkg::WIN_H; y++)
				begin
					for (int x = 0; x < haar_pkg::WIN_W; x++)
					begin
						o_sums[y * haar_pkg::WIN_W + x] <= area_acc[y][x];
					end
				end
			end
		end
	end

endmodule

//--- verilog/row_line_buffer.sv
`timescale 1ns/1ps

module row_line_buffer (
	input  logic                                                 i_clk_os,
	input  logic                                                 i_reset_os,
	input  logic                                                 i_push,
	input  logic [haar_pkg::PIXEL_W-1:0]                         i_pixel,
	output logic [haar_pkg::WIN_W-1:0][haar_pkg::PIXEL_W-1:0]    o_taps,
	output logic [haar_pkg::PIXEL_W-1:0]                         o_pixel_out
);

	// entry 0 is the newest pixel of this row
	logic [haar_pkg::PIXEL_W-1:0] mem [haar_pkg::FRAME_W];

	always_ff @(posedge i_clk_os)
	begin
		if (i_reset_os)
		begin
			for (int i = 0; i < haar_pkg::FRAME_W; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (i_push)
		begin
			mem[0] <= i_pixel;
			for (int i = 1; i < haar_pkg::FRAME_W; i++)
			begin
				mem[i] <= mem[i-1];
			end
		end
	end

	// tap j is the pixel pushed j pushes ago
	always_comb
	begin
		for (int j = 0; j < haar_pkg::WIN_W; j++)
		begin
			o_taps[j] = mem[j];
		end
	end

	// oldest entry moves on to the next row
	assign o_pixel_out = mem[haar_pkg::FRAME_W-1];

endmodule

//--- verilog/wb_pixel_port.sv
`timescale 1ns/1ps

module wb_pixel_port (
	input  logic                             i_clk_os,
	input  logic                             i_reset_os,
	input  logic                             i_wb_cyc,
	input  logic                             i_wb_stb,
	input  logic                             i_wb_we,
	input  logic [haar_pkg::WB_ADDR_W-1:0]   i_wb_adr,
	input  logic [haar_pkg::WB_DATA_W-1:0]   i_wb_dat,
	output logic                             o_wb_ack,
	output logic                             o_push,
	output logic [haar_pkg::PIXEL_W-1:0]     o_pixel,
	output logic [haar_pkg::WB_ADDR_W-1:0]   o_rd_adr
);

	logic                           ack_q;
	logic                           pixel_wr_q;
	logic [haar_pkg::PIXEL_W-1:0]   pixel_q;
	logic [haar_pkg::WB_ADDR_W-1:0] adr_q;
	logic                           req_new;

	// a request not yet answered; the ack cycle itself never starts another
	assign req_new = i_wb_cyc & i_wb_stb & ~ack_q;

	always_ff @(posedge i_clk_os)
	begin
		if (i_reset_os)
		begin
			ack_q <= 1'b0;
			pixel_wr_q <= 1'b0;
			adr_q <= '0;
		end
		else
		begin
			ack_q <= req_new;
			if (req_new)
			begin
				pixel_wr_q <= i_wb_we && (i_wb_adr == haar_pkg::ADDR_PIXEL);
				adr_q <= i_wb_adr;
			end
		end
	end

	// pixel data captured with the request
	always_ff @(posedge i_clk_os)
	begin
		if (req_new)
			pixel_q <= i_wb_dat[haar_pkg::PIXEL_W-1:0];
	end

	assign o_wb_ack = ack_q;
	// push lands on the edge that closes the ack cycle
	assign o_push = ack_q & pixel_wr_q;
	assign o_pixel = pixel_q;
	assign o_rd_adr = adr_q;

endmodule

//--- verilog/haar_pkg.sv
package haar_pkg;

	// pixel and integral value widths
	localparam int PIXEL_W = 8;
	// largest sum is 9 * 255 = 2295
	localparam int SUM_W = 12;

	// window geometry
	localparam int WIN_W = 3;
	localparam int WIN_H = 3;
	localparam int WIN_N = WIN_W * WIN_H;

	// pixels per image row, also the depth of each line buffer
	localparam int FRAME_W = 10;

	// pushes until the window holds only real pixels
	localparam int READY_COUNT = (WIN_H - 1) * FRAME_W + WIN_W;
	localparam int READY_CNT_W = $clog2(READY_COUNT + 1);

	// wishbone bus widths
	localparam int WB_ADDR_W = 4;
	localparam int WB_DATA_W = 16;

	// word map; window entry (y, x) sits at ADDR_WIN_BASE + y * WIN_W + x
	localparam logic [WB_ADDR_W-1:0] ADDR_PIXEL = 4'd0;
	localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 4'd1;
	localparam logic [WB_ADDR_W-1:0] ADDR_WIN_BASE = 4'd2;

endpackage
